// File: rtl/uartPkg.sv
// Fixed 8E2 receive format at 64 clocks per bit; host credit counter must stay below 256
`default_nettype none

package uartPkg;

	// Frame format: start, data, even parity, stop
	localparam int unsigned DataBits = 8;
	localparam int unsigned StopBits = 2;
	localparam int unsigned FrameBits = 1 + DataBits + 1 + StopBits;

	// Oversampling, one bit is OverSample * SampleDiv clocks
	localparam int unsigned OverSample = 16;
	localparam int unsigned SampleDiv = 4;

	// Start is confirmed half a bit after the falling edge
	localparam int unsigned StartSamples = OverSample / 2;

	// Queue size, also the initial credit of the deframer
	localparam int unsigned FifoDepth = 8;

	// Rts drops at or below this many credits
	localparam int unsigned RtsLow = 2;

	// Error flags carried with each word
	localparam int unsigned ErrWidth = 4;
	localparam int unsigned ErrFrame = 0;
	localparam int unsigned ErrParity = 1;
	localparam int unsigned ErrBreak = 2;
	localparam int unsigned ErrOverrun = 3;

	// Counter widths
	localparam int unsigned TickWidth = $clog2(SampleDiv);
	localparam int unsigned PhaseWidth = $clog2(OverSample);
	localparam int unsigned BitCntWidth = $clog2(FrameBits);
	localparam int unsigned CreditWidth = $clog2(FifoDepth + 1);
	localparam int unsigned PtrWidth = $clog2(FifoDepth);
	localparam int unsigned HostCreditWidth = 8;

endpackage

`default_nettype wire

// File: rtl/uartWordIf.sv
// Credit is a one-cycle pulse per freed slot; the consumer must take every Push
`timescale 1ns/1ps
`default_nettype none

interface uartWordIf
	import uartPkg::*;
();

	// Word path from deframer to queue
	logic Push;
	logic [DataBits-1:0] Data;
	logic [ErrWidth-1:0] Err;

	// Slot returned by the queue
	logic Credit;

	modport producer
	(
		output Push,
		output Data,
		output Err,
		input Credit
	);

	modport consumer
	(
		input Push,
		input Data,
		input Err,
		output Credit
	);

endinterface

`default_nettype wire

// File: rtl/rxSampler.sv
// Line must idle high; a low line after the last stop bit holds the sampler until it rises
`timescale 1ns/1ps
`default_nettype none

module rxSampler
	import uartPkg::*;
(
	input wire Clk,
	input wire Rst,
	input wire RxIn,
	output logic BitStrobe,
	output logic BitValue,
	output logic FrameStart
);

	typedef enum logic [1:0] {SIdle, SStart, SBits, SWaitHigh} sampStateType;

	sampStateType state;
	logic rxMeta;
	logic rxSync;
	logic [TickWidth-1:0] tickCnt;
	logic tick;
	logic [PhaseWidth-1:0] phase;
	logic [BitCntWidth-1:0] bitCnt;
	logic [1:0] history;
	logic vote;

	// Two-flop synchronizer, idles high
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= RxIn;
			rxSync <= rxMeta;
		end
	end

	// Sample tick every SampleDiv clocks, phase restarts at the start edge
	assign tick = (state != SIdle) && (tickCnt == TickWidth'(SampleDiv - 1));

	// Majority of the two previous samples and the current one
	assign vote = (history[1] & history[0]) | (history[1] & rxSync) | (history[0] & rxSync);

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= SIdle;
			tickCnt <= '0;
			phase <= '0;
			bitCnt <= '0;
			history <= 2'b11;
			BitStrobe <= 1'b0;
			BitValue <= 1'b1;
			FrameStart <= 1'b0;
		end
		else
		begin
			BitStrobe <= 1'b0;
			FrameStart <= 1'b0;
			if ((state == SIdle) || tick)
				tickCnt <= '0;
			else
				tickCnt <= tickCnt + 1'b1;
			if (tick)
				history <= {history[0], rxSync};
			case (state)
				SIdle:
					if (!rxSync)
					begin
						state <= SStart;
						phase <= '0;
					end
				SStart:
					// Any high sample before mid-bit is a glitch
					if (rxSync)
						state <= SIdle;
					else if (tick)
					begin
						if (phase == PhaseWidth'(StartSamples - 1))
						begin
							state <= SBits;
							phase <= '0;
							bitCnt <= '0;
							BitStrobe <= 1'b1;
							BitValue <= 1'b0;
							FrameStart <= 1'b1;
						end
						else
							phase <= phase + 1'b1;
					end
				SBits:
					if (tick)
					begin
						if (phase == PhaseWidth'(OverSample - 1))
						begin
							phase <= '0;
							bitCnt <= bitCnt + 1'b1;
							BitStrobe <= 1'b1;
							BitValue <= vote;
							// Data, parity and stop bits follow the start bit
							if (bitCnt == BitCntWidth'(FrameBits - 2))
								state <= SWaitHigh;
						end
						else
							phase <= phase + 1'b1;
					end
				SWaitHigh:
					if (rxSync)
						state <= SIdle;
				default:
					state <= SIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/rxDeframer.sv
// Word outputs are valid only with Push; a frame finished without credit is lost
`timescale 1ns/1ps
`default_nettype none

module rxDeframer
	import uartPkg::*;
(
	input wire Clk,
	input wire Rst,
	input wire BitStrobe,
	input wire BitValue,
	input wire FrameStart,
	uartWordIf.producer Word,
	output logic Rts
);

	typedef enum logic [2:0] {Idle, Data, Parity, Stop, Done} frameStateType;

	frameStateType state;
	logic [BitCntWidth-1:0] bitCnt;
	logic [DataBits-1:0] dataReg;
	logic parityAcc;
	logic parityBit;
	logic [StopBits-1:0] stopReg;
	logic stopGood;
	logic [ErrWidth-1:0] errNow;
	logic pushNow;
	logic [CreditWidth-1:0] creditCnt;
	logic creditLoaded;
	logic overrunPending;

	// Frame FSM, the start strobe itself is consumed by FrameStart
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= Idle;
			bitCnt <= '0;
		end
		else
		begin
			case (state)
				Idle:
					if (FrameStart)
					begin
						state <= Data;
						bitCnt <= '0;
					end
				Data:
					if (BitStrobe)
					begin
						if (bitCnt == BitCntWidth'(DataBits - 1))
						begin
							state <= Parity;
							bitCnt <= '0;
						end
						else
							bitCnt <= bitCnt + 1'b1;
					end
				Parity:
					if (BitStrobe)
						state <= Stop;
				Stop:
					if (BitStrobe)
					begin
						if (bitCnt == BitCntWidth'(StopBits - 1))
							state <= Done;
						else
							bitCnt <= bitCnt + 1'b1;
					end
				Done:
					state <= Idle;
				default:
					state <= Idle;
			endcase
		end
	end

	// Shift registers, first data bit ends up as the MSB
	always_ff @(posedge Clk)
	begin
		if ((state == Idle) && FrameStart)
			parityAcc <= 1'b0;
		else if ((state == Data) && BitStrobe)
		begin
			dataReg <= (dataReg << 1) | DataBits'(BitValue);
			parityAcc <= parityAcc ^ BitValue;
		end
		if ((state == Parity) && BitStrobe)
			parityBit <= BitValue;
		if ((state == Stop) && BitStrobe)
			stopReg <= (stopReg << 1) | StopBits'(BitValue);
	end

	assign stopGood = (stopReg == '1);

	always_comb
	begin
		errNow = '0;
		errNow[ErrFrame] = !stopGood;
		// Even parity: data plus parity bit has an even count of ones
		errNow[ErrParity] = (parityAcc != parityBit);
		errNow[ErrBreak] = (dataReg == '0) && !stopGood;
		errNow[ErrOverrun] = overrunPending;
	end

	assign pushNow = (state == Done) && (creditCnt != '0);

	assign Word.Push = pushNow;
	assign Word.Err = errNow;
	assign Word.Data = (errNow != '0) ? '0 : dataReg;

	// Credits start at zero and load the full depth one cycle after reset
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			creditCnt <= '0;
			creditLoaded <= 1'b0;
			overrunPending <= 1'b0;
		end
		else
		begin
			if (!creditLoaded)
			begin
				creditCnt <= CreditWidth'(FifoDepth);
				creditLoaded <= 1'b1;
			end
			else
				creditCnt <= creditCnt + CreditWidth'(Word.Credit) - CreditWidth'(pushNow);
			// Dropped frame leaves its overrun on the next stored word
			if (pushNow)
				overrunPending <= 1'b0;
			else if (state == Done)
				overrunPending <= 1'b1;
		end
	end

	assign Rts = (creditCnt > CreditWidth'(RtsLow));

endmodule

`default_nettype wire

// File: rtl/rxCreditFifo.sv
// Relies on the producer never pushing into a full queue; host output regs hold between pops
`timescale 1ns/1ps
`default_nettype none

module rxCreditFifo
	import uartPkg::*;
(
	input wire Clk,
	input wire Rst,
	uartWordIf.consumer Word,
	input wire HostCredit,
	output logic HostValid,
	output logic [DataBits-1:0] HostData,
	output logic [ErrWidth-1:0] HostErr
);

	logic [ErrWidth+DataBits-1:0] mem [FifoDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic [CreditWidth-1:0] fill;
	logic [HostCreditWidth-1:0] hostCredits;
	logic popNow;
	logic creditPulse;

	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(FifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// A word leaves when the host has credit and the queue holds something
	assign popNow = (hostCredits != '0) && (fill != '0);

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			hostCredits <= '0;
			HostValid <= 1'b0;
			creditPulse <= 1'b0;
		end
		else
		begin
			HostValid <= popNow;
			// Slot goes back to the deframer together with the host word
			creditPulse <= popNow;
			if (Word.Push)
				wrPtr <= nextPtr(wrPtr);
			if (popNow)
				rdPtr <= nextPtr(rdPtr);
			fill <= fill + CreditWidth'(Word.Push) - CreditWidth'(popNow);
			hostCredits <= hostCredits + HostCreditWidth'(HostCredit)
				- HostCreditWidth'(popNow);
		end
	end

	// Storage and host word
	always_ff @(posedge Clk)
	begin
		if (Word.Push)
			mem[wrPtr] <= {Word.Err, Word.Data};
		if (popNow)
			{HostErr, HostData} <= mem[rdPtr];
	end

	assign Word.Credit = creditPulse;

endmodule

`default_nettype wire

// File: rtl/uartRxTop.sv
// HostCredit is a one-cycle pulse per word the host can take; HostData is valid only with HostValid
`timescale 1ns/1ps
`default_nettype none

module uartRxTop
	import uartPkg::*;
(
	input wire Clk,
	input wire Rst,
	input wire RxIn,
	input wire HostCredit,
	output wire Rts,
	output wire HostValid,
	output wire [DataBits-1:0] HostData,
	output wire [ErrWidth-1:0] HostErr
);

	// Sampler to deframer strobes
	logic bitStrobe;
	logic bitValue;
	logic frameStart;

	uartWordIf wordLink ();

	rxSampler i_rxSampler
	(
		.Clk(Clk),
		.Rst(Rst),
		.RxIn(RxIn),
		.BitStrobe(bitStrobe),
		.BitValue(bitValue),
		.FrameStart(frameStart)
	);

	rxDeframer i_rxDeframer
	(
		.Clk(Clk),
		.Rst(Rst),
		.BitStrobe(bitStrobe),
		.BitValue(bitValue),
		.FrameStart(frameStart),
		.Word(wordLink.producer),
		.Rts(Rts)
	);

	rxCreditFifo i_rxCreditFifo
	(
		.Clk(Clk),
		.Rst(Rst),
		.Word(wordLink.consumer),
		.HostCredit(HostCredit),
		.HostValid(HostValid),
		.HostData(HostData),
		.HostErr(HostErr)
	);

endmodule

`default_nettype wire

// File: sim/uartRx_props.sv
// Bound into uartRxTop; both credit counts are tracked here from the pulses on the word link and HostCredit
`timescale 1ns/1ps
`default_nettype none

module uartRxProps
	import uartPkg::*;
(
	input wire Clk,
	input wire Rst,
	input wire Rts,
	input wire HostCredit,
	input wire HostValid,
	input wire [DataBits-1:0] HostData,
	input wire [ErrWidth-1:0] HostErr,
	input wire Push,
	input wire Credit
);

	logic [CreditWidth-1:0] freeSlots;
	logic [HostCreditWidth-1:0] hostGrants;

	// Queue slots the deframer may still fill, seen from the word link
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			freeSlots <= CreditWidth'(FifoDepth);
		else
			freeSlots <= freeSlots + CreditWidth'(Credit) - CreditWidth'(Push);
	end

	// Host credits granted and not yet used by a word
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
			hostGrants <= '0;
		else
			hostGrants <= hostGrants + HostCreditWidth'(HostCredit)
				- HostCreditWidth'(HostValid);
	end

	// Producer side of the credit rule
	pushNeedsCredit: assert property (@(posedge Clk) disable iff (Rst)
		Push |-> (freeSlots != '0))
		else $error("Push while no queue slot was free");

	// A host word is only sent against a host credit
	validNeedsCredit: assert property (@(posedge Clk) disable iff (Rst)
		HostValid |-> (hostGrants != '0))
		else $error("HostValid without a host credit");

	rtsLowInReset: assert property (@(posedge Clk) Rst |-> !Rts)
		else $error("Rts high during reset");

	rtsLowAfterReset: assert property (@(posedge Clk) $fell(Rst) |-> !Rts)
		else $error("Rts high in the first cycle after reset");

	// Flagged words carry no data
	errorZeroesData: assert property (@(posedge Clk) disable iff (Rst)
		(HostValid && (HostErr != '0)) |-> (HostData == '0))
		else $error("HostData nonzero on a flagged word");

endmodule

bind uartRxTop uartRxProps i_uartRxProps
(
	.Clk(Clk),
	.Rst(Rst),
	.Rts(Rts),
	.HostCredit(HostCredit),
	.HostValid(HostValid),
	.HostData(HostData),
	.HostErr(HostErr),
	.Push(wordLink.Push),
	.Credit(wordLink.Credit)
);

`default_nettype wire

// File: sim/uartRxTb.sv
// Run from the project root so the trace path resolves; trace credits must cover every stored word
`timescale 1ns/1ps
`default_nettype none

module uartRxTb
	import uartPkg::*;
();

	localparam int ClkPeriod = 8;
	localparam int StimDelay = 1;
	localparam int ResetCycles = 8;
	localparam int BitClocks = int'(OverSample * SampleDiv);
	// Twelve frame bits plus one bit of room for gaps and credits
	localparam int FrameSlotBits = 13;
	localparam int SlackClocks = 4000;
	localparam int Fields = 5;
	localparam int MaxFrames = 64;
	localparam logic [31:0] Seed = 32'h2d7f;
	localparam string TracePath = "sim/uartRxTrace.txt";

	logic Clk;
	logic Rst;
	logic RxIn;
	logic HostCredit;
	wire Rts;
	wire HostValid;
	wire [DataBits-1:0] HostData;
	wire [ErrWidth-1:0] HostErr;

	logic [15:0] traceMem [0:Fields*MaxFrames-1];
	logic [15:0] expQ [$];
	logic [15:0] expWord;
	logic [31:0] rngState;
	int numFrames;
	int storedCount;
	int poppedCount;
	logic traceReady;

	uartRxTop i_uartRxTop
	(
		.Clk(Clk),
		.Rst(Rst),
		.RxIn(RxIn),
		.HostCredit(HostCredit),
		.Rts(Rts),
		.HostValid(HostValid),
		.HostData(HostData),
		.HostErr(HostErr)
	);

	initial
	begin
		Clk = 1'b0;
		forever
			#(ClkPeriod / 2) Clk = ~Clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] value);
		logic [31:0] x;
		x = value;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic haltOnFailure();
		$display("Something failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %0h, expected %0h", $time, what, actual, expected);
			haltOnFailure();
		end
	endtask

	// Inputs change a little after the rising edge
	task automatic stepClocks(input int count);
		repeat (count) @(posedge Clk);
		#StimDelay;
	endtask

	task automatic sendBit(input logic value);
		RxIn = value;
		stepClocks(BitClocks);
	endtask

	task automatic sendFrame(input logic [DataBits-1:0] data, input logic flipParity,
		input logic [StopBits-1:0] stop);
		int i;
		sendBit(1'b0);
		for (i = DataBits - 1; i >= 0; i--)
			sendBit(data[i]);
		// Even parity, inverted on request
		sendBit((^data) ^ flipParity);
		for (i = StopBits - 1; i >= 0; i--)
			sendBit(stop[i]);
	endtask

	task automatic sendGlitch(input int lowClocks);
		RxIn = 1'b0;
		stepClocks(lowClocks);
		RxIn = 1'b1;
	endtask

	task automatic grantCredits(input int count);
		int k;
		for (k = 0; k < count; k++)
		begin
			rngState = xorshift32(rngState);
			stepClocks(1 + int'(rngState[1:0]));
			HostCredit = 1'b1;
			stepClocks(1);
			HostCredit = 1'b0;
		end
	endtask

	task automatic idleGap();
		rngState = xorshift32(rngState);
		stepClocks(8 + int'(rngState[4:0]));
	endtask

	initial
	begin
		int base;
		int line;
		logic [15:0] wanted;
		logic rtsExpected;
		Rst = 1'b1;
		RxIn = 1'b1;
		HostCredit = 1'b0;
		traceReady = 1'b0;
		storedCount = 0;
		poppedCount = 0;
		rngState = Seed;
		// Unread slots stay above any data value
		for (base = 0; base < Fields * MaxFrames; base++)
			traceMem[base] = 16'hf000 | 16'(base);
		$readmemh(TracePath, traceMem);
		numFrames = 0;
		while ((numFrames < MaxFrames) && (traceMem[numFrames * Fields] <= 16'h00ff))
			numFrames++;
		traceReady = 1'b1;
		if (numFrames == 0)
		begin
			$display("The trace file holds no frames");
			haltOnFailure();
		end
		stepClocks(ResetCycles);
		Rst = 1'b0;
		stepClocks(4);
		checkValue(32'(Rts), 32'd1, "Rts after reset");
		for (line = 0; line < numFrames; line++)
		begin
			base = line * Fields;
			wanted = traceMem[base + 4];
			// Bit 12 marks a frame that leaves no word
			if (!wanted[12])
			begin
				expQ.push_back(wanted);
				storedCount++;
			end
			if (traceMem[base + 1][1:0] == 2'd2)
				sendGlitch(int'(traceMem[base]));
			else
				sendFrame(traceMem[base][DataBits-1:0], traceMem[base + 1][0],
					traceMem[base + 2][StopBits-1:0]);
			RxIn = 1'b1;
			rtsExpected = (int'(FifoDepth) - storedCount + poppedCount) > int'(RtsLow);
			checkValue(32'(Rts), 32'(rtsExpected), "Rts after frame");
			grantCredits(int'(traceMem[base + 3]));
			idleGap();
		end
		while (expQ.size() != 0)
			stepClocks(1);
		// Quiet time so a stray word would still show up
		stepClocks(4 * BitClocks);
		checkValue(32'(Rts), 32'd1, "Rts after drain");
		$display("Everything OK");
		$finish;
	end

	// Scoreboard, outputs sampled away from the rising edge
	always @(negedge Clk)
	begin
		if (!Rst && HostValid)
		begin
			if (expQ.size() == 0)
			begin
				$display("HostValid arrived while no word was expected");
				haltOnFailure();
			end
			else
			begin
				expWord = expQ.pop_front();
				checkValue(32'(HostData), 32'(expWord[DataBits-1:0]), "HostData");
				checkValue(32'(HostErr), 32'(expWord[11:8]), "HostErr");
				poppedCount++;
			end
		end
	end

	initial
	begin
		int limit;
		wait (traceReady);
		limit = numFrames * BitClocks * FrameSlotBits + SlackClocks;
		repeat (limit) @(posedge Clk);
		$display("Timeout: the run did not end within %0d clocks", limit);
		$display("Something failed");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: sim/uartRxTrace.txt
// Columns: data, parity (0 correct, 1 inverted, 2 low glitch of data clocks), stop bits (bit 1 first)
// then host credits granted after the frame, expected {err, data}; 1000 means no word
// Clean frames
55 0 3 1 0055
a3 0 3 1 00a3
01 0 3 1 0001
ff 0 3 1 00ff
80 0 3 1 0080
// Wrong parity bit
5a 1 3 1 0200
00 1 3 1 0200
// Bad stop bits, with and without break
c4 0 1 1 0100
3c 0 2 1 0100
00 0 0 1 0500
00 0 2 1 0500
7e 1 0 1 0300
// Short glitches on an idle line, then a clean frame
0c 2 3 0 1000
14 2 3 0 1000
69 0 3 1 0069
// Host withholds credits until the queue is full
f1 0 3 0 00f1
f2 0 3 0 00f2
f3 0 3 0 00f3
f4 0 3 0 00f4
f5 0 3 0 00f5
f6 0 3 0 00f6
f7 0 3 0 00f7
f8 0 3 0 00f8
// Two frames dropped, credits resume after the second
f9 0 3 0 1000
fa 1 3 8 1000
// Next stored word carries the overrun
2b 0 3 1 0800
// Partial back-pressure, then full drain
c3 0 3 0 00c3
3c 0 3 0 003c
99 0 3 3 0099
e7 0 3 1 00e7

// File: vlog.f
rtl/uartPkg.sv
rtl/uartWordIf.sv
rtl/rxSampler.sv
rtl/rxDeframer.sv
rtl/rxCreditFifo.sv
rtl/uartRxTop.sv
sim/uartRx_props.sv
sim/uartRxTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = uartRxTb
FILELIST = vlog.f
OBJDIR = obj_dir

.PHONY: sim clean

# The simulation exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
